/* flash_dump_pkg.sv */
// -------------------------------------
// widths, spi command, timing constants
// and line layout of the flash dump
// -------------------------------------
package flash_dump_pkg;

// ---------------------------------------
// widths
// ---------------------------------------
localparam int DATA_BITS = 8;
localparam int ADDR_BITS = 24;
localparam int CMD_BITS = 8;

// ---------------------------------------
// spi flash
// ---------------------------------------
// plain read, no dummy cycles
localparam logic [CMD_BITS-1:0] READ_CMD = 8'h03;

// clk27 cycles per half period of flash_clk
localparam int SPI_HALF_CYCLES = 1;

// command and address go out, one byte comes back
localparam int SPI_OUT_BITS = CMD_BITS + ADDR_BITS;
localparam int SPI_EDGES = 2 * (SPI_OUT_BITS + DATA_BITS);
localparam int SPI_DATA_EDGE = 2 * SPI_OUT_BITS;

// ---------------------------------------
// uart, 27 MHz / 115200
// ---------------------------------------
localparam int CLKS_PER_BIT = 234;
// start + data + stop
localparam int UART_FRAME_BITS = DATA_BITS + 2;

// ---------------------------------------
// line layout
// ---------------------------------------
localparam int ADDR_GROUPS = 3;
localparam int LINE_CHARS = 45;
localparam logic [15:0] LINE_GAP_CYCLES = 16'd1000;

endpackage

/* spi_flash_reader.sv */
`timescale 1ns/1ps
// -------------------------------------
// spi mode 0 reader, one byte per read
// -------------------------------------
module spi_flash_reader (
	input  logic clk27,
	input  logic rst,
	input  logic read_start,
	input  logic [flash_dump_pkg::ADDR_BITS-1:0] read_addr,
	output logic read_done,
	output logic [flash_dump_pkg::DATA_BITS-1:0] read_data,
	output logic flash_clk,
	output logic flash_sel,
	output logic flash_out,
	input  logic flash_in
);

typedef enum logic [1:0] {
	st_idle,
	st_shift,
	st_finish
} state_t;

typedef logic [$clog2(flash_dump_pkg::SPI_HALF_CYCLES + 1)-1:0] half_t;
typedef logic [$clog2(flash_dump_pkg::SPI_EDGES)-1:0] edge_t;

state_t state;
half_t half_cnt;
// counts flash_clk edges, rising ones are even
edge_t edge_cnt;
logic [flash_dump_pkg::SPI_OUT_BITS-1:0] tx_sr;
logic [flash_dump_pkg::DATA_BITS-1:0] rx_sr;

logic half_end;
logic rise;
logic fall;

assign half_end = (state == st_shift) &&
	(half_cnt == half_t'(flash_dump_pkg::SPI_HALF_CYCLES - 1));
assign rise = half_end && !flash_clk;
assign fall = half_end && flash_clk;

// msb first, the next bit shows up on every falling edge
assign flash_out = tx_sr[flash_dump_pkg::SPI_OUT_BITS-1];
assign read_data = rx_sr;

// ---------------------------------------
// bus sequencing
// ---------------------------------------
always_ff @(posedge clk27 or posedge rst) begin
	if (rst) begin
		state <= st_idle;
		half_cnt <= '0;
		edge_cnt <= '0;
		tx_sr <= '0;
		flash_clk <= 1'b0;
		flash_sel <= 1'b1;
		read_done <= 1'b0;
	end else begin
		read_done <= 1'b0;
		case (state)
			st_idle: begin
				if (read_start) begin
					// first bit is valid before the first rising edge
					tx_sr <= {flash_dump_pkg::READ_CMD, read_addr};
					half_cnt <= '0;
					edge_cnt <= '0;
					flash_sel <= 1'b0;
					state <= st_shift;
				end
			end
			st_shift: begin
				if (half_end) begin
					half_cnt <= '0;
					flash_clk <= ~flash_clk;
					edge_cnt <= edge_cnt + 1'b1;
				end else begin
					half_cnt <= half_cnt + 1'b1;
				end
				if (fall) begin
					tx_sr <= {tx_sr[flash_dump_pkg::SPI_OUT_BITS-2:0], 1'b0};
					if (edge_cnt == edge_t'(flash_dump_pkg::SPI_EDGES - 1))
						state <= st_finish;
				end
			end
			st_finish: begin
				flash_sel <= 1'b1;
				read_done <= 1'b1;
				state <= st_idle;
			end
			default: state <= st_idle;
		endcase
	end
end

// data byte comes in after command and address
always_ff @(posedge clk27) begin
	if (rise && edge_cnt >= edge_t'(flash_dump_pkg::SPI_DATA_EDGE))
		rx_sr <= {rx_sr[flash_dump_pkg::DATA_BITS-2:0], flash_in};
end

// flash must be deselected and its clock parked between reads
assert property (@(posedge clk27) disable iff (rst)
	(state == st_idle) |-> (flash_sel && !flash_clk))
	else $error("flash selected or clocked while reader idle");

endmodule

/* dump_line_formatter.sv */
`timescale 1ns/1ps
// -------------------------------------
// read sequencing and text line output
// -------------------------------------
module dump_line_formatter (
	input  logic clk27,
	input  logic rst,
	output logic read_start,
	output logic [flash_dump_pkg::ADDR_BITS-1:0] read_addr,
	input  logic read_done,
	input  logic [flash_dump_pkg::DATA_BITS-1:0] read_data,
	output logic char_valid,
	output logic [flash_dump_pkg::DATA_BITS-1:0] char_data,
	input  logic char_ready
);

typedef enum logic [3:0] {
	st_gap,
	st_read,
	st_addr_bit,
	st_under,
	st_colon,
	st_sp_addr,
	st_data,
	st_sp_bin,
	st_data_bit,
	st_sp_hex,
	st_zero,
	st_x,
	st_hex_hi,
	st_hex_lo,
	st_cr,
	st_lf
} state_t;

typedef logic [$clog2(flash_dump_pkg::DATA_BITS)-1:0] bit_t;
typedef logic [$clog2(flash_dump_pkg::ADDR_GROUPS)-1:0] grp_t;

state_t state;
logic [15:0] gap_cnt;
bit_t bit_cnt;
grp_t grp;
int addr_idx;
logic accept;

// nibble to upper case ascii
function automatic logic [7:0] hex_char(input logic [3:0] nib);
	if (nib < 4'd10)
		return 8'h30 + {4'h0, nib};
	return 8'h37 + {4'h0, nib};
endfunction

// address is printed msb first, group by group
assign addr_idx = flash_dump_pkg::ADDR_BITS - 1 -
	(int'(grp) * flash_dump_pkg::DATA_BITS + int'(bit_cnt));

assign char_valid = (state != st_gap) && (state != st_read);
assign accept = char_valid && char_ready;

// ---------------------------------------
// sequencing
// ---------------------------------------
always_ff @(posedge clk27 or posedge rst) begin
	if (rst) begin
		state <= st_gap;
		gap_cnt <= '0;
		bit_cnt <= '0;
		grp <= '0;
		read_start <= 1'b0;
		read_addr <= '0;
	end else begin
		read_start <= 1'b0;
		case (state)
			st_gap: begin
				if (gap_cnt == flash_dump_pkg::LINE_GAP_CYCLES - 16'd1) begin
					gap_cnt <= '0;
					read_start <= 1'b1;
					state <= st_read;
				end else begin
					gap_cnt <= gap_cnt + 1'b1;
				end
			end
			st_read: if (read_done) state <= st_addr_bit;
			st_addr_bit: begin
				if (accept) begin
					if (bit_cnt == bit_t'(flash_dump_pkg::DATA_BITS - 1)) begin
						bit_cnt <= '0;
						if (grp == grp_t'(flash_dump_pkg::ADDR_GROUPS - 1)) begin
							grp <= '0;
							state <= st_colon;
						end else begin
							grp <= grp + 1'b1;
							state <= st_under;
						end
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			end
			st_under: if (accept) state <= st_addr_bit;
			st_colon: if (accept) state <= st_sp_addr;
			st_sp_addr: if (accept) state <= st_data;
			st_data: if (accept) state <= st_sp_bin;
			st_sp_bin: if (accept) state <= st_data_bit;
			st_data_bit: begin
				if (accept) begin
					if (bit_cnt == bit_t'(flash_dump_pkg::DATA_BITS - 1)) begin
						bit_cnt <= '0;
						state <= st_sp_hex;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			end
			st_sp_hex: if (accept) state <= st_zero;
			st_zero: if (accept) state <= st_x;
			st_x: if (accept) state <= st_hex_hi;
			st_hex_hi: if (accept) state <= st_hex_lo;
			st_hex_lo: if (accept) state <= st_cr;
			st_cr: if (accept) state <= st_lf;
			st_lf: begin
				// line done, wraps at the top of the flash
				if (accept) begin
					read_addr <= read_addr + 1'b1;
					state <= st_gap;
				end
			end
			default: state <= st_gap;
		endcase
	end
end

// ---------------------------------------
// character to print
// ---------------------------------------
always_comb begin
	case (state)
		st_addr_bit: char_data = read_addr[addr_idx] ? "1" : "0";
		st_under: char_data = "_";
		st_colon: char_data = ":";
		st_data: char_data = read_data;
		st_data_bit: begin
			char_data = read_data[flash_dump_pkg::DATA_BITS - 1 - int'(bit_cnt)] ? "1" : "0";
		end
		st_sp_addr, st_sp_bin, st_sp_hex: char_data = " ";
		st_zero: char_data = "0";
		st_x: char_data = "x";
		st_hex_hi: char_data = hex_char(read_data[7:4]);
		st_hex_lo: char_data = hex_char(read_data[3:0]);
		st_cr: char_data = 8'h0d;
		st_lf: char_data = 8'h0a;
		default: char_data = '0;
	endcase
end

// an offered character holds until the transmitter takes it
assert property (@(posedge clk27) disable iff (rst)
	(char_valid && !char_ready) |=> (char_valid && $stable(char_data)))
	else $error("character changed before it was accepted");

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps
// -------------------------------------
// 8N1 uart transmitter
// -------------------------------------
module uart_tx #(
	parameter int clks_per_bit = 234
) (
	input  logic clk27,
	input  logic rst,
	input  logic char_valid,
	input  logic [flash_dump_pkg::DATA_BITS-1:0] char_data,
	output logic char_ready,
	output logic serial_tx
);

typedef logic [$clog2(clks_per_bit + 1)-1:0] baud_t;
typedef logic [$clog2(flash_dump_pkg::UART_FRAME_BITS)-1:0] frame_cnt_t;

logic busy;
baud_t baud_cnt;
frame_cnt_t bit_cnt;
// start bit at bit 0 and stop bit at the top
logic [flash_dump_pkg::UART_FRAME_BITS-1:0] frame;

assign char_ready = ~busy;
assign serial_tx = frame[0];

always_ff @(posedge clk27 or posedge rst) begin
	if (rst) begin
		busy <= 1'b0;
		baud_cnt <= '0;
		bit_cnt <= '0;
		// line idles high
		frame <= '1;
	end else if (!busy) begin
		if (char_valid) begin
			frame <= {1'b1, char_data, 1'b0};
			baud_cnt <= '0;
			bit_cnt <= '0;
			busy <= 1'b1;
		end
	end else if (baud_cnt == baud_t'(clks_per_bit - 1)) begin
		// bit period over
		baud_cnt <= '0;
		frame <= {1'b1, frame[flash_dump_pkg::UART_FRAME_BITS-1:1]};
		if (bit_cnt == frame_cnt_t'(flash_dump_pkg::UART_FRAME_BITS - 1))
			busy <= 1'b0;
		else
			bit_cnt <= bit_cnt + 1'b1;
	end else begin
		baud_cnt <= baud_cnt + 1'b1;
	end
end

// a low line means a frame is still going out
assert property (@(posedge clk27) disable iff (rst)
	!serial_tx |-> !char_ready)
	else $error("ready raised while a frame is on the line");

endmodule

/* flash_dump_top.sv */
`timescale 1ns/1ps
// -------------------------------------
// flash reader, line formatter and uart
// -------------------------------------
module flash_dump_top (
	input  logic clk27,
	input  logic rst,
	output logic serial_tx,
	output logic flash_clk,
	output logic flash_sel,
	output logic flash_out,
	input  logic flash_in
);

// ---------------------------------------
// reader to formatter
// ---------------------------------------
logic read_start;
logic [flash_dump_pkg::ADDR_BITS-1:0] read_addr;
logic read_done;
logic [flash_dump_pkg::DATA_BITS-1:0] read_data;

// ---------------------------------------
// formatter to uart
// ---------------------------------------
logic char_valid;
logic char_ready;
logic [flash_dump_pkg::DATA_BITS-1:0] char_data;

spi_flash_reader u_reader (
	.clk27      (clk27),
	.rst        (rst),
	.read_start (read_start),
	.read_addr  (read_addr),
	.read_done  (read_done),
	.read_data  (read_data),
	.flash_clk  (flash_clk),
	.flash_sel  (flash_sel),
	.flash_out  (flash_out),
	.flash_in   (flash_in)
);

dump_line_formatter u_formatter (
	.clk27      (clk27),
	.rst        (rst),
	.read_start (read_start),
	.read_addr  (read_addr),
	.read_done  (read_done),
	.read_data  (read_data),
	.char_valid (char_valid),
	.char_data  (char_data),
	.char_ready (char_ready)
);

uart_tx #(
	.clks_per_bit (flash_dump_pkg::CLKS_PER_BIT)
) u_uart (
	.clk27      (clk27),
	.rst        (rst),
	.char_valid (char_valid),
	.char_data  (char_data),
	.char_ready (char_ready),
	.serial_tx  (serial_tx)
);

endmodule

/* spi_flash_model.sv */
`timescale 1ns/1ps
// ----------------------------------------
// behavioral spi flash, 256 random bytes
// ----------------------------------------
module spi_flash_model (
	input  logic spi_clk,
	input  logic spi_sel,
	input  logic spi_mosi,
	output logic spi_miso
);

logic [7:0] mem [256];
// last command seen, read by the testbench
logic [7:0] last_cmd = 8'h00;
logic [23:0] last_addr = 24'h000000;
logic [31:0] shift_in = 32'h0;
int bit_cnt = 0;
int seed;
int data_bit;
logic miso_q = 1'b0;

assign spi_miso = miso_q;

initial begin
	seed = 17;
	for (int i = 0; i < 256; i++)
		mem[i] = 8'($random(seed));
end

// ----------------------------------------
// command and address in
// ----------------------------------------
// flash clock is parked low whenever select falls
always @(posedge spi_clk or negedge spi_sel) begin
	if (!spi_clk) begin
		bit_cnt = 0;
	end else if (spi_sel === 1'b0) begin
		shift_in = {shift_in[30:0], spi_mosi};
		bit_cnt = bit_cnt + 1;
		if (bit_cnt == 8)
			last_cmd = shift_in[7:0];
		if (bit_cnt == 32)
			last_addr = shift_in[23:0];
	end
end

// ----------------------------------------
// data out
// ----------------------------------------
// msb first, sequential bytes wrap at 256
always @(negedge spi_clk) begin
	if (spi_sel === 1'b0 && bit_cnt >= 32) begin
		data_bit = bit_cnt - 32;
		miso_q <= mem[8'(last_addr[7:0] + 8'(data_bit / 8))][3'(7 - data_bit % 8)];
	end
end

endmodule

/* tb_flash_dump.sv */
`timescale 1ns/1ps
// ----------------------------------------
// testbench with uart decoder, line model,
// read checks and watchdog
// ----------------------------------------
module tb_flash_dump;

localparam int CLK_NS = 8;
localparam int NUM_LINES = 5;
localparam int MAX_CHARS = 64;
localparam int FRAME_BITS = 10;
localparam int LINE_CHARS = flash_dump_pkg::LINE_CHARS;
localparam int BIT_NS = flash_dump_pkg::CLKS_PER_BIT * CLK_NS;
localparam int HALF_BIT_NS = BIT_NS / 2;
// gap plus room for the spi read
localparam int GAP_NS = (int'(flash_dump_pkg::LINE_GAP_CYCLES) + 100) * CLK_NS;
localparam longint LINE_NS = longint'(LINE_CHARS) * FRAME_BITS * BIT_NS + GAP_NS;
localparam longint TIMEOUT_NS = NUM_LINES * LINE_NS * 3 / 2;

logic clk27;
logic rst;
logic serial_tx;
logic flash_clk;
logic flash_sel;
logic flash_out;
logic flash_in;

int errors = 0;
int reads_seen = 0;
logic [7:0] rx_line [MAX_CHARS];
logic [7:0] exp_line [LINE_CHARS];

flash_dump_top dut (
	.clk27     (clk27),
	.rst       (rst),
	.serial_tx (serial_tx),
	.flash_clk (flash_clk),
	.flash_sel (flash_sel),
	.flash_out (flash_out),
	.flash_in  (flash_in)
);

spi_flash_model u_flash (
	.spi_clk  (flash_clk),
	.spi_sel  (flash_sel),
	.spi_mosi (flash_out),
	.spi_miso (flash_in)
);

initial begin
	clk27 = 1'b0;
	forever #(CLK_NS / 2) clk27 = ~clk27;
end

task automatic report_mismatch(input string msg);
	$display("[FAIL] %0t: %s", $time, msg);
	errors++;
endtask

task automatic check_idle_pins(input string phase);
	if (serial_tx !== 1'b1 || flash_sel !== 1'b1 || flash_clk !== 1'b0)
		report_mismatch($sformatf("%s: tx=%b sel=%b clk=%b, expected 1 1 0",
			phase, serial_tx, flash_sel, flash_clk));
endtask

// ----------------------------------------
// uart decoding
// ----------------------------------------
// sampled in the middle of every bit
task automatic receive_frame(output logic [7:0] ch);
	@(negedge serial_tx);
	#(HALF_BIT_NS);
	if (serial_tx !== 1'b0)
		report_mismatch("start bit not held low");
	for (int i = 0; i < 8; i++) begin
		#(BIT_NS);
		ch[i] = serial_tx;
	end
	#(BIT_NS);
	if (serial_tx !== 1'b1)
		report_mismatch($sformatf("bad stop bit after character 0x%02h", ch));
endtask

task automatic receive_line(output int count);
	logic [7:0] ch;
	logic seen_lf;
	count = 0;
	seen_lf = 1'b0;
	while (!seen_lf && count < MAX_CHARS) begin
		receive_frame(ch);
		rx_line[count] = ch;
		count++;
		// only cr then lf ends a line
		seen_lf = (ch == 8'h0a) && (count >= 2) && (rx_line[count - 2] == 8'h0d);
	end
	if (!seen_lf) begin
		$display("no CR LF arrived within %0d characters", MAX_CHARS);
		errors++;
	end
endtask

// ----------------------------------------
// reference line
// ----------------------------------------
task automatic build_expected(input logic [23:0] addr, input logic [7:0] data);
	string head;
	string tail;
	string hex;
	int pos;
	head = $sformatf("%08b_%08b_%08b: ", addr[23:16], addr[15:8], addr[7:0]);
	hex = $sformatf("%02h", data);
	tail = {$sformatf(" %08b 0x", data), hex.toupper()};
	pos = 0;
	for (int i = 0; i < head.len(); i++) begin
		exp_line[pos] = head[i];
		pos++;
	end
	// raw byte sits between the two text parts
	exp_line[pos] = data;
	pos++;
	for (int i = 0; i < tail.len(); i++) begin
		exp_line[pos] = tail[i];
		pos++;
	end
	exp_line[pos] = 8'h0d;
	exp_line[pos + 1] = 8'h0a;
endtask

task automatic check_line(input int line, input int count);
	int n;
	if (count != LINE_CHARS)
		report_mismatch($sformatf("line %0d holds %0d characters, expected %0d",
			line, count, LINE_CHARS));
	n = (count < LINE_CHARS) ? count : LINE_CHARS;
	for (int i = 0; i < n; i++) begin
		if (rx_line[i] !== exp_line[i])
			report_mismatch($sformatf("line %0d char %0d: got 0x%02h, expected 0x%02h",
				line, i, rx_line[i], exp_line[i]));
	end
endtask

// each finished read must carry the next sequential address
initial begin
	@(negedge rst);
	forever begin
		@(posedge flash_sel);
		if (u_flash.last_cmd !== 8'h03)
			report_mismatch($sformatf("read %0d: opcode 0x%02h, expected 0x03",
				reads_seen, u_flash.last_cmd));
		if (u_flash.last_addr !== 24'(reads_seen))
			report_mismatch($sformatf("read %0d: address 0x%06h, expected 0x%06h",
				reads_seen, u_flash.last_addr, 24'(reads_seen)));
		reads_seen++;
	end
end

// ----------------------------------------
// main sequence
// ----------------------------------------
initial begin : main_seq
	int count;
	rst = 1'b1;
	repeat (3) begin
		@(posedge clk27);
		#1;
		check_idle_pins("in reset");
	end
	rst = 1'b0;
	@(posedge clk27);
	#1;
	check_idle_pins("after reset");
	for (int line = 0; line < NUM_LINES; line++) begin
		receive_line(count);
		build_expected(24'(line), u_flash.mem[8'(line)]);
		check_line(line, count);
	end
	if (reads_seen < NUM_LINES)
		report_mismatch($sformatf("only %0d flash reads seen", reads_seen));
	$display("errors: %0d, lines checked: %0d", errors, NUM_LINES);
	if (errors == 0)
		$display("Test OK");
	else
		$display("Test FAILED");
	$finish;
end

initial begin
	#(TIMEOUT_NS);
	$display("watchdog: run timed out at %0t before all lines arrived", $time);
	$display("errors: %0d", errors);
	$display("Test FAILED");
	$finish;
end

endmodule

/* sources.f */
flash_dump_pkg.sv
spi_flash_reader.sv
dump_line_formatter.sv
uart_tx.sv
flash_dump_top.sv
spi_flash_model.sv
tb_flash_dump.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_flash_dump
FILELIST   := sources.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing
PASS_MSG   := Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
